/* adc_frontend_top.f */
+incdir+hdl
hdl/spi_pkg.sv
hdl/adc_pkg.sv
hdl/adc_ctrl_if.sv
hdl/spi_slave_port.sv
hdl/cmd_decoder.sv
hdl/dual_slope_sequencer.sv
hdl/adc_frontend_top.sv
bench/tb_adc_frontend_top.sv

/* bench/tb_adc_frontend_top.sv */
// SPI master runs at 5 clk per SCK half-period and the comparator is driven as a plain bit
`timescale 1ns/1ps
`include "adc_consts.svh"

module tb_adc_frontend_top;

  localparam logic [7:0] CMD_CONVERT   = 8'hcc;
  localparam logic [7:0] CMD_SET_RESET = 8'ha1;
  localparam logic [7:0] CMD_SET_RUNUP = 8'ha2;
  localparam logic [7:0] CMD_JUNK      = 8'h5a;

  logic clk = 1'b0;
  logic rst_n, sck, ssel, mosi, t_trigger;
  logic miso, m_reset, m_in, m_ref, led1, led2, led3, led4;

  // edge counter and monitor results
  int cyc = 0;
  int sck_rise_cyc, drop_cyc, cmd_cyc;
  int rst_rise_cyc, rst_fall_cyc, in_rise_cyc, in_fall_cyc, high_cnt;
  int r_len, u_len, d_len, expected;
  logic m_reset_q = 1'b0;
  logic m_in_q = 1'b0;
  logic [31:0] seed = 32'h1d14;
  logic [31:0] busy_word, word;
  logic [7:0] junk_rx;

  adc_frontend_top uut (
    .clk (clk), .rst_n (rst_n), .sck (sck), .ssel (ssel), .mosi (mosi),
    .t_trigger (t_trigger), .miso (miso), .m_reset (m_reset), .m_in (m_in),
    .m_ref (m_ref), .led1 (led1), .led2 (led2), .led3 (led3), .led4 (led4)
  );

  always #50 clk = ~clk;

  always @(posedge clk)
    cyc <= cyc + 1;

  ////////////////////////////////////////////////////////////
  // failure reporting and checks

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "stopping on first error");
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else
      fail_now($sformatf("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp));
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  ////////////////////////////////////////////////////////////
  // monitor samples on the falling edge where outputs are settled
  always @(negedge clk)
  begin
    if (m_reset && !m_reset_q)
    begin
      rst_rise_cyc = cyc;
      high_cnt = 1;
    end
    else if (m_reset)
      high_cnt++;
    if (!m_reset && m_reset_q)
      rst_fall_cyc = cyc;
    if (m_in && !m_in_q)
      in_rise_cyc = cyc;
    if (!m_in && m_in_q)
      in_fall_cyc = cyc;
    m_reset_q = m_reset;
    m_in_q = m_in;
    // switch drive and LED wiring hold every cycle
    check_eq("m_ref", 32'(m_ref), 32'(!m_in));
    check_eq("led1", 32'(led1), 32'(m_reset));
    check_eq("led2", 32'(led2), 32'(m_in));
    check_eq("led3", 32'(led3), 32'(m_ref));
    check_eq("led4", 32'(led4), 32'(t_trigger));
    assert (!(m_in && !m_reset))
    else
      fail_now("m_in went high while m_reset was low");
  end

  ////////////////////////////////////////////////////////////
  // mode 0 SPI master

  // inputs change 10 ns after the rising edge
  task automatic tick();
    @(posedge clk);
    #10;
  endtask

  task automatic spi_begin();
    ssel = 1'b0;
    repeat (5) tick();
  endtask

  task automatic spi_end();
    repeat (5) tick();
    ssel = 1'b1;
    repeat (6) tick();
  endtask

  task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
    for (int i = 7; i >= 0; i--)
    begin
      mosi = tx[i];
      repeat (5) tick();
      // miso settled well before the rise
      rx[i] = miso;
      sck = 1'b1;
      sck_rise_cyc = cyc;
      repeat (5) tick();
      sck = 1'b0;
    end
  endtask

  task automatic send_set(input logic [7:0] op, input logic [31:0] value);
    logic [31:0] v;
    logic [7:0] rx;
    v = value;
    spi_begin();
    spi_byte(op, rx);
    for (int k = 0; k < `SPI_ARG_BYTES; k++)
    begin
      spi_byte(v[31:24], rx);
      v = v << 8;
    end
    spi_end();
  endtask

  task automatic read_word(output logic [31:0] w);
    logic [7:0] rx;
    spi_begin();
    for (int k = 0; k < 4; k++)
    begin
      // zero bytes are ignored by the decoder
      spi_byte(8'h00, rx);
      w = {w[23:0], rx};
    end
    spi_end();
  endtask

  ////////////////////////////////////////////////////////////
  // comparator model and waits

  task automatic drop_trigger(input int delay);
    int waited;
    waited = 0;
    while (!m_in)
    begin
      tick();
      waited++;
      if (waited > 2000)
        fail_now("m_in never rose during the conversion");
    end
    repeat (delay) tick();
    // integrator crosses zero
    t_trigger = 1'b0;
    drop_cyc = cyc;
  endtask

  task automatic wait_reset_low();
    int waited;
    waited = 0;
    while (m_reset)
    begin
      tick();
      waited++;
      if (waited > 200)
        fail_now("m_reset did not fall after the comparator dropped");
    end
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  initial
  begin
    rst_n = 1'b0;
    sck = 1'b0;
    ssel = 1'b1;
    mosi = 1'b0;
    t_trigger = 1'b0;
    repeat (4) @(posedge clk);
    #10;
    rst_n = 1'b1;
    tick();
    check_eq("m_reset", 32'(m_reset), 32'd0);
    check_eq("m_in", 32'(m_in), 32'd0);

    for (int conv = 0; conv < 3; conv++)
    begin
      seed = xorshift32(seed);
      r_len = 20 + (seed % 64);
      seed = xorshift32(seed);
      u_len = 20 + (seed % 64);
      seed = xorshift32(seed);
      d_len = 1 + (seed % 64);
      send_set(CMD_SET_RESET, r_len);
      send_set(CMD_SET_RUNUP, u_len);
      if (conv == 2)
      begin
        // unknown byte while idle changes nothing
        spi_begin();
        spi_byte(CMD_JUNK, junk_rx);
        spi_end();
        // a stray start would raise m_reset inside this window
        for (int k = 0; k < r_len + 8; k++)
        begin
          check_eq("m_reset", 32'(m_reset), 32'd0);
          check_eq("m_in", 32'(m_in), 32'd0);
          tick();
        end
        // SET cut short after two argument bytes leaves the old length
        spi_begin();
        spi_byte(CMD_SET_RESET, junk_rx);
        spi_byte(8'h00, junk_rx);
        spi_byte(8'h05, junk_rx);
        spi_end();
      end
      t_trigger = 1'b1;
      spi_begin();
      spi_byte(CMD_CONVERT, junk_rx);
      // sync, rx_valid, cmd_valid, then the sequencer edge
      cmd_cyc = sck_rise_cyc + 5;
      spi_end();
      fork
        read_word(busy_word);
        drop_trigger(d_len);
      join
      check_eq("result while busy", busy_word, 32'd0);
      wait_reset_low();
      tick();
      read_word(word);
      expected = u_len + d_len + 3;
      check_eq("m_reset rise cycle", rst_rise_cyc, cmd_cyc + r_len);
      check_eq("m_in rise cycle", in_rise_cyc, rst_rise_cyc + u_len);
      check_eq("m_reset fall cycle", rst_fall_cyc, drop_cyc + 3);
      check_eq("m_in fall cycle", in_fall_cyc, drop_cyc + 3);
      check_eq("m_reset high clocks", high_cnt, expected);
      check_eq("spi result", word, expected);
    end

    $display("Simulation passed");
    $finish;
  end

endmodule

/* hdl/adc_consts.svh */
// every length counts clk cycles and the synchronizer depth must be 3 or more
`ifndef ADC_CONSTS_SVH
`define ADC_CONSTS_SVH

////////////////////////////////////////////////////////////
// sequencer phase lengths after power-up

// integrator held shorted for about 10 ms at a 10 MHz clk
`define ADC_DEFAULT_RESET_CYCLES 100000
// input integrated for about 0.1 s
`define ADC_DEFAULT_RUNUP_CYCLES 1000000
// width of every cycle count
`define ADC_COUNT_BITS 32

////////////////////////////////////////////////////////////
// serial side
`define ADC_SYNC_STAGES 3
`define SPI_BYTE_BITS 8
`define SPI_WORD_BITS 32
// argument bytes that follow a SET opcode
`define SPI_ARG_BYTES 4

`endif

/* hdl/adc_ctrl_if.sv */
// no clock of its own and no back-pressure so a command is taken in the cycle it is valid
`timescale 1ns/1ps

interface adc_ctrl_if;
  import adc_pkg::*;

  // command from the decoder
  // cmd_valid is a one-cycle pulse
  logic        cmd_valid;
  adc_opcode_e opcode;
  // only meaningful with the SET opcodes
  adc_count_t  arg;

  // status from the sequencer
  logic        busy;
  // zero while a conversion runs
  adc_count_t  result;

  modport decoder (
    output cmd_valid,
    output opcode,
    output arg
  );

  modport sequencer (
    input  cmd_valid,
    input  opcode,
    input  arg,
    output busy,
    output result
  );

endinterface

/* hdl/adc_frontend_top.sv */
// one slave on the bus so miso always drives and t_trigger may change at any time
`timescale 1ns/1ps

module adc_frontend_top (
  input  logic clk,
  input  logic rst_n,
  input  logic sck,
  input  logic ssel,
  input  logic mosi,
  input  logic t_trigger,
  output logic miso,
  output logic m_reset,
  output logic m_in,
  output logic m_ref,
  output logic led1,
  output logic led2,
  output logic led3,
  output logic led4
);
  import spi_pkg::*;

  adc_ctrl_if ctrl_bus ();

  spi_byte_t rx_byte;
  logic      rx_valid;
  logic      ssel_active;
  spi_word_t tx_word;

  // latched count goes straight back out on MISO
  assign tx_word = ctrl_bus.result;

  spi_slave_port u_spi (
    .clk         (clk),
    .rst_n       (rst_n),
    .sck         (sck),
    .ssel        (ssel),
    .mosi        (mosi),
    .tx_word     (tx_word),
    .miso        (miso),
    .rx_byte     (rx_byte),
    .rx_valid    (rx_valid),
    .ssel_active (ssel_active)
  );

  cmd_decoder u_dec (
    .clk         (clk),
    .rst_n       (rst_n),
    .ssel_active (ssel_active),
    .rx_byte     (rx_byte),
    .rx_valid    (rx_valid),
    .ctrl        (ctrl_bus.decoder)
  );

  dual_slope_sequencer u_seq (
    .clk       (clk),
    .rst_n     (rst_n),
    .t_trigger (t_trigger),
    .m_reset   (m_reset),
    .m_in      (m_in),
    .ctrl      (ctrl_bus.sequencer)
  );

  // analog switch takes either the input or the reference
  assign m_ref = ~m_in;

  // status LEDs
  assign led1 = m_reset;
  assign led2 = m_in;
  assign led3 = m_ref;
  assign led4 = t_trigger;

endmodule

/* hdl/adc_pkg.sv */
// opcode bytes are fixed by the host software and any other byte is ignored
`include "adc_consts.svh"

package adc_pkg;

  // cycle count for phase lengths and the conversion result
  typedef logic [`ADC_COUNT_BITS-1:0] adc_count_t;

  // first byte of a command
  typedef enum logic [7:0] {
    OP_NONE      = 8'h00,
    OP_CONVERT   = 8'hcc,
    OP_SET_RESET = 8'ha1,
    OP_SET_RUNUP = 8'ha2
  } adc_opcode_e;

  // dual-slope phases
  // reset shorts the integrator, run-up takes the input
  // run-down takes the reference until the comparator falls
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_RESET,
    ST_RUNUP,
    ST_RUNDOWN
  } adc_state_e;

endpackage

/* hdl/cmd_decoder.sv */
// SET arguments must arrive in the same transaction as their opcode or they are dropped
`timescale 1ns/1ps
`include "adc_consts.svh"

module cmd_decoder (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               ssel_active,
  input  spi_pkg::spi_byte_t rx_byte,
  input  logic               rx_valid,
  adc_ctrl_if.decoder        ctrl
);
  import adc_pkg::*;

  typedef enum logic {
    DEC_OPCODE,
    DEC_ARG
  } dec_state_e;

  localparam int ARG_CNT_W = $clog2(`SPI_ARG_BYTES);
  localparam int ARG_W     = $bits(adc_count_t);
  localparam int BYTE_W    = $bits(rx_byte);

  dec_state_e           dec_state;
  logic [ARG_CNT_W-1:0] arg_cnt;
  adc_opcode_e          byte_op;

  // map a raw byte to an opcode
  always_comb
  begin
    case (rx_byte)
      OP_CONVERT:   byte_op = OP_CONVERT;
      OP_SET_RESET: byte_op = OP_SET_RESET;
      OP_SET_RUNUP: byte_op = OP_SET_RUNUP;
      default:      byte_op = OP_NONE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      dec_state      <= DEC_OPCODE;
      arg_cnt        <= '0;
      ctrl.cmd_valid <= 1'b0;
      ctrl.opcode    <= OP_NONE;
    end
    else
    begin
      ctrl.cmd_valid <= 1'b0;
      // ssel rising throws away a half-read argument
      if (!ssel_active)
        dec_state <= DEC_OPCODE;
      else if (rx_valid)
      begin
        case (dec_state)
          DEC_OPCODE:
          begin
            // opcode stays put while the argument comes in
            ctrl.opcode <= byte_op;
            arg_cnt     <= '0;
            if (byte_op == OP_CONVERT)
              ctrl.cmd_valid <= 1'b1;
            else if (byte_op != OP_NONE)
              dec_state <= DEC_ARG;
          end
          DEC_ARG:
          begin
            arg_cnt <= arg_cnt + 1'b1;
            if (arg_cnt == ARG_CNT_W'(`SPI_ARG_BYTES - 1))
            begin
              ctrl.cmd_valid <= 1'b1;
              dec_state      <= DEC_OPCODE;
            end
          end
          default: dec_state <= DEC_OPCODE;
        endcase
      end
    end
  end

  // argument bytes shift in MSB first
  always_ff @(posedge clk)
  begin
    if (rx_valid && ssel_active && (dec_state == DEC_ARG))
      ctrl.arg <= {ctrl.arg[ARG_W-BYTE_W-1:0], rx_byte};
  end

  // one pulse per command
  a_single_pulse: assert property (
    @(posedge clk) disable iff (!rst_n)
    ctrl.cmd_valid |=> !ctrl.cmd_valid
  );

endmodule

/* hdl/dual_slope_sequencer.sv */
// phase lengths must be at least 1 and run-down hangs until the comparator falls or a new CONVERT
`timescale 1ns/1ps
`include "adc_consts.svh"

module dual_slope_sequencer (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          t_trigger,
  output logic          m_reset,
  output logic          m_in,
  adc_ctrl_if.sequencer ctrl
);
  import adc_pkg::*;

  localparam int SYNC_N = `ADC_SYNC_STAGES;

  adc_state_e        state;
  adc_count_t        reset_cycles;
  adc_count_t        runup_cycles;
  // counts clocks inside the current phase
  adc_count_t        phase_cnt;
  // counts clocks since m_reset rose
  adc_count_t        integ_cnt;
  logic [SYNC_N-1:0] trig_sync;
  logic              trig_fall;
  logic              start;

  // a CONVERT also restarts a running conversion
  assign start = ctrl.cmd_valid && (ctrl.opcode == OP_CONVERT);

  ////////////////////////////////////////////////////////////
  // phase length registers
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      reset_cycles <= adc_count_t'(`ADC_DEFAULT_RESET_CYCLES);
      runup_cycles <= adc_count_t'(`ADC_DEFAULT_RUNUP_CYCLES);
    end
    else if (ctrl.cmd_valid)
    begin
      case (ctrl.opcode)
        OP_SET_RESET: reset_cycles <= ctrl.arg;
        OP_SET_RUNUP: runup_cycles <= ctrl.arg;
        default:      ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // comparator synchronizer
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      trig_sync <= '0;
    else
      trig_sync <= {trig_sync[SYNC_N-2:0], t_trigger};
  end

  // integrator crossed zero
  assign trig_fall = ~trig_sync[SYNC_N-2] & trig_sync[SYNC_N-1];

  ////////////////////////////////////////////////////////////
  // phase FSM
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state       <= ST_IDLE;
      ctrl.busy   <= 1'b0;
      m_reset     <= 1'b0;
      m_in        <= 1'b0;
      phase_cnt   <= '0;
      integ_cnt   <= '0;
      ctrl.result <= '0;
    end
    else if (start)
    begin
      // short the integrator and hide the old result
      state       <= ST_RESET;
      ctrl.busy   <= 1'b1;
      m_reset     <= 1'b0;
      m_in        <= 1'b0;
      phase_cnt   <= adc_count_t'(1);
      ctrl.result <= '0;
    end
    else
    begin
      phase_cnt <= phase_cnt + 1'b1;
      integ_cnt <= integ_cnt + 1'b1;
      case (state)
        ST_RESET:
        begin
          if (phase_cnt == reset_cycles)
          begin
            // release the short and start on the input
            m_reset   <= 1'b1;
            phase_cnt <= adc_count_t'(1);
            integ_cnt <= adc_count_t'(1);
            state     <= ST_RUNUP;
          end
        end
        ST_RUNUP:
        begin
          // swap to the reference
          if (phase_cnt == runup_cycles)
          begin
            m_in  <= 1'b1;
            state <= ST_RUNDOWN;
          end
        end
        ST_RUNDOWN:
        begin
          if (trig_fall)
          begin
            m_reset     <= 1'b0;
            m_in        <= 1'b0;
            // clocks that m_reset was high
            ctrl.result <= integ_cnt;
            ctrl.busy   <= 1'b0;
            state       <= ST_IDLE;
          end
        end
        // idle just waits for CONVERT
        default: ;
      endcase
    end
  end

  // reference only switched in while integrating
  a_in_needs_reset: assert property (
    @(posedge clk) disable iff (!rst_n)
    m_in |-> m_reset
  );

  a_busy_tracks_state: assert property (
    @(posedge clk) disable iff (!rst_n)
    (state == ST_IDLE) == !ctrl.busy
  );

endmodule

/* hdl/spi_pkg.sv */
// widths follow the shared constants header and all SPI data travels MSB first
`include "adc_consts.svh"

package spi_pkg;

  // one byte shifted in on MOSI
  typedef logic [`SPI_BYTE_BITS-1:0] spi_byte_t;

  // readback word shifted out on MISO
  // holds the latched integration count
  typedef logic [`SPI_WORD_BITS-1:0] spi_word_t;

endpackage

/* hdl/spi_slave_port.sv */
// SPI mode 0 with one slave on the bus and SCK half-periods of at least 4 clk cycles
`timescale 1ns/1ps
`include "adc_consts.svh"

module spi_slave_port (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               sck,
  input  logic               ssel,
  input  logic               mosi,
  input  spi_pkg::spi_word_t tx_word,
  output logic               miso,
  output spi_pkg::spi_byte_t rx_byte,
  output logic               rx_valid,
  output logic               ssel_active
);
  import spi_pkg::*;

  localparam int SYNC_N = `ADC_SYNC_STAGES;
  localparam int BYTE_W = $bits(spi_byte_t);
  localparam int WORD_W = $bits(spi_word_t);

  logic [SYNC_N-1:0] sck_sync;
  logic [SYNC_N-1:0] ssel_sync;
  logic [SYNC_N-2:0] mosi_sync;
  logic              sck_rise;
  logic              sck_fall;
  logic              ssel_fall;
  logic              mosi_bit;
  logic [$clog2(BYTE_W)-1:0] bit_cnt;
  spi_byte_t         rx_shift;
  spi_word_t         tx_shift;

  ////////////////////////////////////////////////////////////
  // input synchronizers
  // ssel idles high so it starts inactive
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sck_sync  <= '0;
      ssel_sync <= '1;
      mosi_sync <= '0;
    end
    else
    begin
      sck_sync  <= {sck_sync[SYNC_N-2:0], sck};
      ssel_sync <= {ssel_sync[SYNC_N-2:0], ssel};
      mosi_sync <= {mosi_sync[SYNC_N-3:0], mosi};
    end
  end

  // last stage only remembers the previous level for edge detection
  assign sck_rise    = sck_sync[SYNC_N-2] & ~sck_sync[SYNC_N-1];
  assign sck_fall    = ~sck_sync[SYNC_N-2] & sck_sync[SYNC_N-1];
  assign ssel_fall   = ~ssel_sync[SYNC_N-2] & ssel_sync[SYNC_N-1];
  assign ssel_active = ~ssel_sync[SYNC_N-2];
  // sampled at the same depth as sck so the bit lines up with its rise
  assign mosi_bit    = mosi_sync[SYNC_N-2];

  ////////////////////////////////////////////////////////////
  // receive path
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
    end
    else
    begin
      // pulse once the eighth bit is in
      rx_valid <= ssel_active && sck_rise && (bit_cnt == '1);
      // realigns on every new transaction
      if (!ssel_active)
        bit_cnt <= '0;
      else if (sck_rise)
        bit_cnt <= bit_cnt + 1'b1;
    end
  end

  // MSB arrives first
  always_ff @(posedge clk)
  begin
    if (ssel_active && sck_rise)
      rx_shift <= {rx_shift[BYTE_W-2:0], mosi_bit};
  end

  assign rx_byte = rx_shift;

  ////////////////////////////////////////////////////////////
  // transmit path
  // word captured at the start of every transaction
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      tx_shift <= '0;
    else if (ssel_fall)
      tx_shift <= tx_word;
    else if (ssel_active && sck_fall)
      tx_shift <= {tx_shift[WORD_W-2:0], 1'b0};
  end

  // master samples on the next rise
  assign miso = tx_shift[WORD_W-1];

  // a byte only completes inside a transaction
  a_rx_inside_frame: assert property (
    @(posedge clk) disable iff (!rst_n)
    rx_valid |-> ssel_active
  );

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and checks the log
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f adc_frontend_top.f \
  --top-module tb_adc_frontend_top -o sim_adc
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_adc > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation passed" "$LOG"; then
  exit 0
fi
echo "pass line not found in $LOG"
exit 1
